//--- Makefile
TOP := io_glb_tb

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f io_glb.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: compile run clean

//--- io_glb.f
+incdir+rtl
rtl/glb_data_pkg.sv
rtl/glb_config_pkg.sv
rtl/io_bank_if.sv
rtl/glb_bank.sv
rtl/io_controller.sv
rtl/io_config_regs.sv
rtl/io_bank_interconnect.sv
rtl/io_glb_top.sv
testbench/io_glb_tb.sv

//--- rtl/glb_bank.sv
/*
 * global buffer memory bank
 * 256 words, one write and one registered read port,
 * read data valid one edge after rd_en
 */
`timescale 1ns/1ps
`default_nettype none

`include "glb_consts.svh"

module glb_bank (
    input  logic      clk,
    input  logic      reset,
    bank_port_if.mem  port
);

    localparam int DEPTH = 2 ** `GLB_BANK_ADDR_W;

    glb_data_pkg::data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            mem[port.wr_addr] <= port.wr_data;
        end
    end

    // old data on a same-address write
    always_ff @(posedge clk) begin
        if (port.rd_en) begin
            port.rd_data <= mem[port.rd_addr];
        end
    end

    a_rd_addr_known: assert property (
        @(posedge clk) disable iff (reset) port.rd_en |-> !$isunknown(port.rd_addr)
    );

endmodule

`default_nettype wire

//--- rtl/glb_config_pkg.sv
/*
 * global buffer configuration types
 * config bus fields, stream modes and per-channel settings
 */
`default_nettype none

`include "glb_consts.svh"

package glb_config_pkg;

    typedef logic [`GLB_CFG_ADDR_W-1:0] cfg_addr_t;
    typedef logic [`GLB_CFG_DATA_W-1:0] cfg_data_t;
    typedef logic [`GLB_NUM_WORDS_W-1:0] word_count_t;

    // one bit per channel above channel 0
    typedef logic [`GLB_NUM_IO-2:0] switch_sel_t;

    typedef enum logic [`GLB_MODE_W-1:0] {
        IDLE         = 2'd0,
        WRITE_STREAM = 2'd1,
        READ_STREAM  = 2'd2
    } stream_mode_e;

    typedef struct packed {
        stream_mode_e            mode;
        glb_data_pkg::glb_addr_t start_addr;
        word_count_t             num_words;
    } io_ctrl_cfg_t;

endpackage

`default_nettype wire

//--- rtl/glb_consts.svh
/*
 * global buffer io side constants
 * channel and bank counts, datapath widths, config field widths
 */
`ifndef GLB_CONSTS_SVH
`define GLB_CONSTS_SVH

// array shape
`define GLB_NUM_IO          2
`define GLB_NUM_BANKS       4
`define GLB_BANKS_PER_IO    2

// datapath
`define GLB_BANK_ADDR_W     8
`define GLB_BANK_SEL_W      2
`define GLB_DATA_W          16

// config bus, upper nibble is feature, lower nibble is register
`define GLB_CFG_ADDR_W      8
`define GLB_CFG_FEATURE_W   4
`define GLB_CFG_REG_W       4
`define GLB_CFG_DATA_W      32
`define GLB_MODE_W          2
`define GLB_NUM_WORDS_W     16

`endif

//--- rtl/glb_data_pkg.sv
/*
 * global buffer datapath types
 * data words, bank word addresses and global addresses
 */
`default_nettype none

`include "glb_consts.svh"

package glb_data_pkg;

    // one cgra / bank word
    typedef logic [`GLB_DATA_W-1:0] data_t;

    // word address inside one bank
    typedef logic [`GLB_BANK_ADDR_W-1:0] bank_addr_t;

    // bank number on top, word address below
    typedef logic [`GLB_BANK_SEL_W+`GLB_BANK_ADDR_W-1:0] glb_addr_t;

endpackage

`default_nettype wire

//--- rtl/io_bank_if.sv
/*
 * io side bundles
 * io_bank_if joins a stream controller to the interconnect,
 * bank_port_if joins the interconnect to one memory bank
 */
`timescale 1ns/1ps
`default_nettype none

interface io_bank_if;
    logic                    wr_en;
    logic                    rd_en;
    glb_data_pkg::glb_addr_t addr;
    glb_data_pkg::data_t     wr_data;
    glb_data_pkg::data_t     rd_data;
    logic                    rd_valid;

    modport ctrl (output wr_en, rd_en, addr, wr_data, input rd_data, rd_valid);
    modport net  (input wr_en, rd_en, addr, wr_data, output rd_data, rd_valid);
endinterface

interface bank_port_if;
    logic                     wr_en;
    glb_data_pkg::bank_addr_t wr_addr;
    glb_data_pkg::data_t      wr_data;
    logic                     rd_en;
    glb_data_pkg::bank_addr_t rd_addr;
    glb_data_pkg::data_t      rd_data;

    modport net (output wr_en, wr_addr, wr_data, rd_en, rd_addr, input rd_data);
    modport mem (input wr_en, wr_addr, wr_data, rd_en, rd_addr, output rd_data);
endinterface

`default_nettype wire

//--- rtl/io_bank_interconnect.sv
/*
 * io to bank interconnect
 * switch chain routes each bank group to its source channel,
 * read data returns two cycles later through a priority chain
 */
`timescale 1ns/1ps
`default_nettype none

`include "glb_consts.svh"

module io_bank_interconnect (
    input  logic                        clk,
    input  logic                        reset,
    input  glb_config_pkg::switch_sel_t switch_sel,
    io_bank_if.net                      io_port   [`GLB_NUM_IO],
    bank_port_if.net                    bank_port [`GLB_NUM_BANKS]
);

    localparam int NUM_IO      = `GLB_NUM_IO;
    localparam int NUM_BANKS   = `GLB_NUM_BANKS;
    localparam int BPI         = `GLB_BANKS_PER_IO;
    localparam int BANK_ADDR_W = `GLB_BANK_ADDR_W;
    localparam int BANK_SEL_W  = `GLB_BANK_SEL_W;
    localparam int IO_IDX_W    = (NUM_IO > 1) ? $clog2(NUM_IO) : 1;

    logic                    io_wr_en      [NUM_IO];
    logic                    io_rd_en      [NUM_IO];
    glb_data_pkg::glb_addr_t io_addr       [NUM_IO];
    glb_data_pkg::data_t     io_wr_data    [NUM_IO];
    logic                    io_valid      [NUM_IO];
    logic                    chain_wr_en   [NUM_IO];
    logic                    chain_rd_en   [NUM_IO];
    glb_data_pkg::glb_addr_t chain_addr    [NUM_IO];
    glb_data_pkg::data_t     chain_wr_data [NUM_IO];
    logic [IO_IDX_W-1:0]     chain_src     [NUM_IO];

    logic                bank_wr_en    [NUM_BANKS];
    logic                bank_rd_en    [NUM_BANKS];
    logic                bank_rd_en_d1 [NUM_BANKS];
    logic                bank_rd_en_d2 [NUM_BANKS];
    glb_data_pkg::data_t bank_rd_data  [NUM_BANKS];
    glb_data_pkg::data_t bank_data_d1  [NUM_BANKS];
    glb_data_pkg::data_t rd_chain      [NUM_BANKS];

    // switch chain, a 0 bit lets the previous group's source through
    always_comb begin
        chain_wr_en[0]   = io_wr_en[0];
        chain_rd_en[0]   = io_rd_en[0];
        chain_addr[0]    = io_addr[0];
        chain_wr_data[0] = io_wr_data[0];
        chain_src[0]     = '0;
        for (int j = 1; j < NUM_IO; j++) begin
            if (switch_sel[j-1]) begin
                chain_wr_en[j]   = io_wr_en[j];
                chain_rd_en[j]   = io_rd_en[j];
                chain_addr[j]    = io_addr[j];
                chain_wr_data[j] = io_wr_data[j];
                chain_src[j]     = IO_IDX_W'(j);
            end else begin
                chain_wr_en[j]   = chain_wr_en[j-1];
                chain_rd_en[j]   = chain_rd_en[j-1];
                chain_addr[j]    = chain_addr[j-1];
                chain_wr_data[j] = chain_wr_data[j-1];
                chain_src[j]     = chain_src[j-1];
            end
        end
    end

    // bank enable needs a matching bank field
    always_comb begin
        for (int k = 0; k < NUM_BANKS; k++) begin
            bank_wr_en[k] = chain_wr_en[k/BPI] &&
                            (chain_addr[k/BPI][BANK_ADDR_W +: BANK_SEL_W] == k);
            bank_rd_en[k] = chain_rd_en[k/BPI] &&
                            (chain_addr[k/BPI][BANK_ADDR_W +: BANK_SEL_W] == k);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < NUM_BANKS; k++) begin
                bank_rd_en_d1[k] <= 1'b0;
                bank_rd_en_d2[k] <= 1'b0;
            end
        end else begin
            for (int k = 0; k < NUM_BANKS; k++) begin
                bank_rd_en_d1[k] <= bank_rd_en[k];
                bank_rd_en_d2[k] <= bank_rd_en_d1[k];
            end
        end
    end

    // return data stage
    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_BANKS; k++) begin
            bank_data_d1[k] <= bank_rd_data[k];
        end
    end

    // priority chain from the top bank down
    always_comb begin
        rd_chain[NUM_BANKS-1] = bank_rd_en_d2[NUM_BANKS-1] ? bank_data_d1[NUM_BANKS-1] : '0;
        for (int k = NUM_BANKS - 2; k >= 0; k--) begin
            rd_chain[k] = bank_rd_en_d2[k] ? bank_data_d1[k] : rd_chain[k+1];
        end
    end

    // valid goes to the channel that owns the returning bank
    always_comb begin
        for (int j = 0; j < NUM_IO; j++) begin
            io_valid[j] = 1'b0;
            for (int k = 0; k < NUM_BANKS; k++) begin
                if (bank_rd_en_d2[k] && chain_src[k/BPI] == IO_IDX_W'(j)) begin
                    io_valid[j] = 1'b1;
                end
            end
        end
    end

    for (genvar j = 0; j < NUM_IO; j++) begin : g_io
        assign io_wr_en[j]         = io_port[j].wr_en;
        assign io_rd_en[j]         = io_port[j].rd_en;
        assign io_addr[j]          = io_port[j].addr;
        assign io_wr_data[j]       = io_port[j].wr_data;
        assign io_port[j].rd_data  = rd_chain[j*BPI];
        assign io_port[j].rd_valid = io_valid[j];

        a_valid_after_read: assert property (
            @(posedge clk) disable iff (reset) io_valid[j] |-> $past(io_rd_en[j], 2)
        );
    end

    for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
        assign bank_port[k].wr_en   = bank_wr_en[k];
        assign bank_port[k].wr_addr = chain_addr[k/BPI][BANK_ADDR_W-1:0];
        assign bank_port[k].wr_data = chain_wr_data[k/BPI];
        assign bank_port[k].rd_en   = bank_rd_en[k];
        assign bank_port[k].rd_addr = chain_addr[k/BPI][BANK_ADDR_W-1:0];
        assign bank_rd_data[k]      = bank_port[k].rd_data;
    end

endmodule

`default_nettype wire

//--- rtl/io_config_regs.sv
/*
 * io configuration register file
 * per-channel mode, start address and word count, plus switch_sel,
 * with combinational readback
 */
`timescale 1ns/1ps
`default_nettype none

`include "glb_consts.svh"

module io_config_regs (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         cfg_en,
    input  logic                         cfg_wr,
    input  logic                         cfg_rd,
    input  glb_config_pkg::cfg_addr_t    cfg_addr,
    input  glb_config_pkg::cfg_data_t    cfg_wr_data,
    output glb_config_pkg::cfg_data_t    cfg_rd_data,
    output glb_config_pkg::io_ctrl_cfg_t io_cfg [`GLB_NUM_IO],
    output glb_config_pkg::switch_sel_t  switch_sel
);

    logic [`GLB_CFG_FEATURE_W-1:0] feature;
    logic [`GLB_CFG_REG_W-1:0]     reg_sel;

    assign feature = cfg_addr[`GLB_CFG_ADDR_W-1 -: `GLB_CFG_FEATURE_W];
    assign reg_sel = cfg_addr[`GLB_CFG_REG_W-1:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            switch_sel <= '0;
            for (int j = 0; j < `GLB_NUM_IO; j++) begin
                io_cfg[j].mode       <= glb_config_pkg::IDLE;
                io_cfg[j].start_addr <= '0;
                io_cfg[j].num_words  <= '0;
            end
        end else if (cfg_en && cfg_wr) begin
            // feature after the last channel is the interconnect
            if (feature == `GLB_NUM_IO && reg_sel == 0) begin
                switch_sel <= glb_config_pkg::switch_sel_t'(cfg_wr_data);
            end
            for (int j = 0; j < `GLB_NUM_IO; j++) begin
                if (feature == j) begin
                    case (reg_sel)
                        0: io_cfg[j].mode <= glb_config_pkg::stream_mode_e'(
                               cfg_wr_data[`GLB_MODE_W-1:0]);
                        1: io_cfg[j].start_addr <= glb_data_pkg::glb_addr_t'(cfg_wr_data);
                        2: io_cfg[j].num_words <= glb_config_pkg::word_count_t'(cfg_wr_data);
                        default: ;
                    endcase
                end
            end
        end
    end

    // unmapped registers fall through as zero
    always_comb begin
        cfg_rd_data = '0;
        if (cfg_en && cfg_rd) begin
            if (feature == `GLB_NUM_IO && reg_sel == 0) begin
                cfg_rd_data = glb_config_pkg::cfg_data_t'(switch_sel);
            end
            for (int j = 0; j < `GLB_NUM_IO; j++) begin
                if (feature == j) begin
                    case (reg_sel)
                        0: cfg_rd_data = glb_config_pkg::cfg_data_t'(io_cfg[j].mode);
                        1: cfg_rd_data = glb_config_pkg::cfg_data_t'(io_cfg[j].start_addr);
                        2: cfg_rd_data = glb_config_pkg::cfg_data_t'(io_cfg[j].num_words);
                        default: cfg_rd_data = '0;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/io_controller.sv
/*
 * io stream controller, one per channel
 * walks sequential global addresses from start_addr for num_words
 * transfers in write-stream or read-stream mode
 */
`timescale 1ns/1ps
`default_nettype none

module io_controller (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start_pulse,
    input  logic                         stall,
    input  logic                         global_stall,
    input  glb_config_pkg::io_ctrl_cfg_t cfg,
    input  logic                         cgra_wr_en,
    input  logic                         cgra_rd_en,
    input  glb_data_pkg::data_t          cgra_wr_data,
    output logic                         cgra_rd_valid,
    output glb_data_pkg::data_t          cgra_rd_data,
    io_bank_if.ctrl                      bank
);

    typedef enum logic [1:0] {
        IDLE,
        ACTIVE,
        DONE
    } ctrl_state_e;

    ctrl_state_e                 state;
    glb_data_pkg::glb_addr_t     addr_q;
    glb_config_pkg::word_count_t count_q;
    glb_config_pkg::word_count_t count_next;
    logic                        halted;
    logic                        accept_wr;
    logic                        accept_rd;

    assign halted = stall | global_stall;

    // a transfer only counts while active and not stalled
    assign accept_wr = (state == ACTIVE) && !halted && cgra_wr_en &&
                       (cfg.mode == glb_config_pkg::WRITE_STREAM);
    assign accept_rd = (state == ACTIVE) && !halted && cgra_rd_en &&
                       (cfg.mode == glb_config_pkg::READ_STREAM);

    assign count_next = count_q + glb_config_pkg::word_count_t'(1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= IDLE;
            addr_q  <= '0;
            count_q <= '0;
        end else if (start_pulse) begin
            addr_q  <= cfg.start_addr;
            count_q <= '0;
            if (cfg.mode == glb_config_pkg::IDLE) begin
                state <= IDLE;
            end else if (cfg.num_words == '0) begin
                state <= DONE;
            end else begin
                state <= ACTIVE;
            end
        end else if (accept_wr || accept_rd) begin
            addr_q  <= addr_q + glb_data_pkg::glb_addr_t'(1);
            count_q <= count_next;
            // last word of the stream
            if (count_next == cfg.num_words) begin
                state <= DONE;
            end
        end
    end

    // request goes out in the same cycle it is accepted
    assign bank.wr_en   = accept_wr;
    assign bank.rd_en   = accept_rd;
    assign bank.addr    = addr_q;
    assign bank.wr_data = cgra_wr_data;

    // in-flight reads still return after done
    assign cgra_rd_valid = bank.rd_valid;
    assign cgra_rd_data  = bank.rd_data;

    a_no_wr_rd_overlap: assert property (
        @(posedge clk) disable iff (reset) !(bank.wr_en && bank.rd_en)
    );

endmodule

`default_nettype wire

//--- rtl/io_glb_top.sv
/*
 * global buffer io side top
 * config registers, stream controllers, interconnect and banks
 */
`timescale 1ns/1ps
`default_nettype none

`include "glb_consts.svh"

module io_glb_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start_pulse,
    input  logic                      global_stall,
    input  logic                      cgra_stall   [`GLB_NUM_IO],
    input  logic                      cgra_wr_en   [`GLB_NUM_IO],
    input  logic                      cgra_rd_en   [`GLB_NUM_IO],
    input  glb_data_pkg::data_t       cgra_wr_data [`GLB_NUM_IO],
    output logic                      io_rd_valid  [`GLB_NUM_IO],
    output glb_data_pkg::data_t       io_rd_data   [`GLB_NUM_IO],
    input  logic                      cfg_en,
    input  logic                      cfg_wr,
    input  logic                      cfg_rd,
    input  glb_config_pkg::cfg_addr_t cfg_addr,
    input  glb_config_pkg::cfg_data_t cfg_wr_data,
    output glb_config_pkg::cfg_data_t cfg_rd_data
);

    glb_config_pkg::io_ctrl_cfg_t io_cfg [`GLB_NUM_IO];
    glb_config_pkg::switch_sel_t  switch_sel;

    io_bank_if   io_bus   [`GLB_NUM_IO] ();
    bank_port_if bank_bus [`GLB_NUM_BANKS] ();

    io_config_regs u_config_regs (
        .clk         (clk),
        .reset       (reset),
        .cfg_en      (cfg_en),
        .cfg_wr      (cfg_wr),
        .cfg_rd      (cfg_rd),
        .cfg_addr    (cfg_addr),
        .cfg_wr_data (cfg_wr_data),
        .cfg_rd_data (cfg_rd_data),
        .io_cfg      (io_cfg),
        .switch_sel  (switch_sel)
    );

    for (genvar j = 0; j < `GLB_NUM_IO; j++) begin : g_ctrl
        io_controller u_ctrl (
            .clk           (clk),
            .reset         (reset),
            .start_pulse   (start_pulse),
            .stall         (cgra_stall[j]),
            .global_stall  (global_stall),
            .cfg           (io_cfg[j]),
            .cgra_wr_en    (cgra_wr_en[j]),
            .cgra_rd_en    (cgra_rd_en[j]),
            .cgra_wr_data  (cgra_wr_data[j]),
            .cgra_rd_valid (io_rd_valid[j]),
            .cgra_rd_data  (io_rd_data[j]),
            .bank          (io_bus[j])
        );
    end

    io_bank_interconnect u_interconnect (
        .clk        (clk),
        .reset      (reset),
        .switch_sel (switch_sel),
        .io_port    (io_bus),
        .bank_port  (bank_bus)
    );

    for (genvar k = 0; k < `GLB_NUM_BANKS; k++) begin : g_bank
        glb_bank u_bank (
            .clk   (clk),
            .reset (reset),
            .port  (bank_bus[k])
        );
    end

endmodule

`default_nettype wire

//--- testbench/io_glb_tb.sv
/*
 * global buffer io side testbench
 * config readback, write and read streams on both channels,
 * chained routing and random stalls against a memory model
 */
`timescale 1ns/1ps
`default_nettype none

`include "glb_consts.svh"

module io_glb_tb;

    localparam int CLK_PERIOD    = 40;
    localparam int NUM_IO        = `GLB_NUM_IO;
    localparam int GLB_DEPTH     = 2 ** (`GLB_BANK_SEL_W + `GLB_BANK_ADDR_W);
    // words moved over all stream phases below
    localparam int TOTAL_WORDS   = 2 * 24 + 4 * 16 + 2 * 20 + 2 * 12 + 4 * 32;
    localparam int MARGIN_CYCLES = 400;

    logic                      clk;
    logic                      reset;
    logic                      start_pulse;
    logic                      global_stall;
    logic                      cgra_stall   [NUM_IO];
    logic                      cgra_wr_en   [NUM_IO];
    logic                      cgra_rd_en   [NUM_IO];
    glb_data_pkg::data_t       cgra_wr_data [NUM_IO];
    logic                      io_rd_valid  [NUM_IO];
    glb_data_pkg::data_t       io_rd_data   [NUM_IO];
    logic                      cfg_en;
    logic                      cfg_wr;
    logic                      cfg_rd;
    glb_config_pkg::cfg_addr_t cfg_addr;
    glb_config_pkg::cfg_data_t cfg_wr_data;
    glb_config_pkg::cfg_data_t cfg_rd_data;

    integer seed;
    int     error_count;

    // reference state
    glb_data_pkg::data_t          model_mem [GLB_DEPTH];
    glb_data_pkg::data_t          exp_q0 [$];
    glb_data_pkg::data_t          exp_q1 [$];
    glb_config_pkg::switch_sel_t  tb_switch;
    glb_config_pkg::stream_mode_e tb_mode   [NUM_IO];
    glb_data_pkg::glb_addr_t      tb_start  [NUM_IO];
    int                           tb_num    [NUM_IO];
    glb_data_pkg::glb_addr_t      tb_addr   [NUM_IO];
    int                           tb_remain [NUM_IO];
    int                           valid_count [NUM_IO];

    io_glb_top DUT (
        .clk          (clk),
        .reset        (reset),
        .start_pulse  (start_pulse),
        .global_stall (global_stall),
        .cgra_stall   (cgra_stall),
        .cgra_wr_en   (cgra_wr_en),
        .cgra_rd_en   (cgra_rd_en),
        .cgra_wr_data (cgra_wr_data),
        .io_rd_valid  (io_rd_valid),
        .io_rd_data   (io_rd_data),
        .cfg_en       (cfg_en),
        .cfg_wr       (cfg_wr),
        .cfg_rd       (cfg_rd),
        .cfg_addr     (cfg_addr),
        .cfg_wr_data  (cfg_wr_data),
        .cfg_rd_data  (cfg_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string what);
        error_count++;
        $display("ERROR: %s", what);
        $display("FAIL: see errors above");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
            fail_run($sformatf("%s differs from the model", name));
        end
    endtask

    // does a request from channel ch at addr reach its bank
    function automatic bit expected_route(input glb_config_pkg::switch_sel_t sel,
                                          input int ch,
                                          input glb_data_pkg::glb_addr_t addr);
        int group;
        int src;
        group = int'(addr[`GLB_BANK_ADDR_W +: `GLB_BANK_SEL_W]) / `GLB_BANKS_PER_IO;
        src   = 0;
        for (int i = 1; i <= group; i++) begin
            if (sel[i-1]) begin
                src = i;
            end
        end
        return src == ch;
    endfunction

    function automatic void push_expected(input int ch, input glb_data_pkg::data_t value);
        if (ch == 0) begin
            exp_q0.push_back(value);
        end else begin
            exp_q1.push_back(value);
        end
    endfunction

    function automatic int pending_reads(input int ch);
        return (ch == 0) ? exp_q0.size() : exp_q1.size();
    endfunction

    function automatic glb_data_pkg::data_t pop_expected(input int ch);
        if (ch == 0) begin
            return exp_q0.pop_front();
        end
        return exp_q1.pop_front();
    endfunction

    // read data is registered in the DUT, stable by the falling edge
    always @(negedge clk) begin : compare_reads
        glb_data_pkg::data_t expected;
        if (!reset) begin
            for (int j = 0; j < NUM_IO; j++) begin
                if (io_rd_valid[j]) begin
                    if (pending_reads(j) == 0) begin
                        fail_run($sformatf("read valid on channel %0d with no read pending", j));
                    end else begin
                        expected = pop_expected(j);
                        check_equal($sformatf("io_rd_data[%0d]", j), io_rd_data[j], expected);
                        valid_count[j]++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * (TOTAL_WORDS * 4 + MARGIN_CYCLES));
        fail_run("simulation timed out before all streams finished");
    end

    function automatic glb_config_pkg::cfg_addr_t cfg_reg_addr(input int feature, input int r);
        return {4'(feature), 4'(r)};
    endfunction

    task automatic cfg_write(input glb_config_pkg::cfg_addr_t addr,
                             input glb_config_pkg::cfg_data_t data);
        @(negedge clk);
        cfg_en      = 1'b1;
        cfg_wr      = 1'b1;
        cfg_addr    = addr;
        cfg_wr_data = data;
        @(negedge clk);
        cfg_en = 1'b0;
        cfg_wr = 1'b0;
    endtask

    task automatic cfg_read(input glb_config_pkg::cfg_addr_t addr,
                            output glb_config_pkg::cfg_data_t data);
        @(negedge clk);
        cfg_en   = 1'b1;
        cfg_rd   = 1'b1;
        cfg_addr = addr;
        #(CLK_PERIOD / 4);
        data = cfg_rd_data;
        @(negedge clk);
        cfg_en = 1'b0;
        cfg_rd = 1'b0;
    endtask

    task automatic write_and_check(input glb_config_pkg::cfg_addr_t addr,
                                   input glb_config_pkg::cfg_data_t data,
                                   input glb_config_pkg::cfg_data_t exp);
        glb_config_pkg::cfg_data_t rd_value;
        cfg_write(addr, data);
        cfg_read(addr, rd_value);
        check_equal($sformatf("cfg_rd_data@0x%0h", addr), rd_value, exp);
    endtask

    task automatic configure_channel(input int ch, input glb_config_pkg::stream_mode_e mode,
                                     input glb_data_pkg::glb_addr_t start, input int num);
        cfg_write(cfg_reg_addr(ch, 0), glb_config_pkg::cfg_data_t'(mode));
        cfg_write(cfg_reg_addr(ch, 1), glb_config_pkg::cfg_data_t'(start));
        cfg_write(cfg_reg_addr(ch, 2), glb_config_pkg::cfg_data_t'(num));
        tb_mode[ch]  = mode;
        tb_start[ch] = start;
        tb_num[ch]   = num;
    endtask

    task automatic set_switch(input glb_config_pkg::switch_sel_t sel);
        cfg_write(cfg_reg_addr(NUM_IO, 0), glb_config_pkg::cfg_data_t'(sel));
        tb_switch = sel;
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start_pulse = 1'b1;
        @(negedge clk);
        start_pulse = 1'b0;
        for (int j = 0; j < NUM_IO; j++) begin
            tb_addr[j]   = tb_start[j];
            tb_remain[j] = (tb_mode[j] == glb_config_pkg::IDLE) ? 0 : tb_num[j];
        end
    endtask

    // enables stay high a few cycles past the last word
    task automatic run_streams(input bit use_stall);
        int                  tail;
        bit                  busy;
        bit                  halt;
        glb_data_pkg::data_t wdata;
        tail = 0;
        busy = 1'b1;
        while (busy || tail < 4) begin
            global_stall = use_stall && (($random(seed) & 7) == 0);
            busy = 1'b0;
            for (int j = 0; j < NUM_IO; j++) begin
                wdata           = glb_data_pkg::data_t'($random(seed));
                cgra_stall[j]   = use_stall && (($random(seed) & 3) == 0);
                cgra_wr_en[j]   = (tb_mode[j] == glb_config_pkg::WRITE_STREAM);
                cgra_rd_en[j]   = (tb_mode[j] == glb_config_pkg::READ_STREAM);
                cgra_wr_data[j] = wdata;
                halt = cgra_stall[j] || global_stall;
                if (tb_remain[j] > 0 && !halt) begin
                    if (expected_route(tb_switch, j, tb_addr[j])) begin
                        if (tb_mode[j] == glb_config_pkg::WRITE_STREAM) begin
                            model_mem[tb_addr[j]] = wdata;
                        end else begin
                            push_expected(j, model_mem[tb_addr[j]]);
                        end
                    end
                    tb_addr[j]   = tb_addr[j] + 1'b1;
                    tb_remain[j] = tb_remain[j] - 1;
                end
                if (tb_remain[j] > 0) begin
                    busy = 1'b1;
                end
            end
            if (!busy) begin
                tail++;
            end
            @(negedge clk);
        end
        global_stall = 1'b0;
        for (int j = 0; j < NUM_IO; j++) begin
            cgra_stall[j] = 1'b0;
            cgra_wr_en[j] = 1'b0;
            cgra_rd_en[j] = 1'b0;
        end
    endtask

    task automatic run_phase(input bit use_stall);
        int exp_valids;
        for (int j = 0; j < NUM_IO; j++) begin
            valid_count[j] = 0;
        end
        pulse_start();
        run_streams(use_stall);
        while (pending_reads(0) != 0 || pending_reads(1) != 0) begin
            @(negedge clk);
        end
        // late valids would show up here
        repeat (4) @(negedge clk);
        // a read stream returns exactly num_words valids
        for (int j = 0; j < NUM_IO; j++) begin
            exp_valids = (tb_mode[j] == glb_config_pkg::READ_STREAM) ? tb_num[j] : 0;
            check_equal($sformatf("valid_count[%0d]", j), valid_count[j], exp_valids);
        end
    endtask

    initial begin
        seed         = 32'h3e43;
        error_count  = 0;
        reset        = 1'b1;
        start_pulse  = 1'b0;
        global_stall = 1'b0;
        cfg_en       = 1'b0;
        cfg_wr       = 1'b0;
        cfg_rd       = 1'b0;
        cfg_addr     = '0;
        cfg_wr_data  = '0;
        tb_switch    = '0;
        for (int j = 0; j < NUM_IO; j++) begin
            cgra_stall[j]   = 1'b0;
            cgra_wr_en[j]   = 1'b0;
            cgra_rd_en[j]   = 1'b0;
            cgra_wr_data[j] = '0;
            tb_mode[j]      = glb_config_pkg::IDLE;
            tb_start[j]     = '0;
            tb_num[j]       = 0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // config readback, fields keep only their own width
        write_and_check(cfg_reg_addr(0, 0), 32'h0000_0001, 32'h1);
        write_and_check(cfg_reg_addr(0, 1), 32'h0000_0115, 32'h115);
        write_and_check(cfg_reg_addr(0, 2), 32'h0001_0007, 32'h7);
        write_and_check(cfg_reg_addr(1, 0), 32'h0000_0002, 32'h2);
        write_and_check(cfg_reg_addr(1, 1), 32'hffff_f2a5, 32'h2a5);
        write_and_check(cfg_reg_addr(1, 2), 32'h0000_0030, 32'h30);
        write_and_check(cfg_reg_addr(2, 0), 32'h0000_0003, 32'h1);
        write_and_check(cfg_reg_addr(0, 3), 32'h1234_5678, 32'h0);
        write_and_check(cfg_reg_addr(2, 1), 32'h0000_00ff, 32'h0);
        write_and_check(cfg_reg_addr(5, 0), 32'h0000_0001, 32'h0);

        // channel 0 alone, crossing bank 0 into bank 1
        set_switch(1'b1);
        configure_channel(0, glb_config_pkg::WRITE_STREAM, 10'h0f0, 24);
        configure_channel(1, glb_config_pkg::IDLE, 10'h000, 0);
        run_phase(1'b0);
        configure_channel(0, glb_config_pkg::READ_STREAM, 10'h0f0, 24);
        run_phase(1'b0);

        // both channels in their own groups
        configure_channel(0, glb_config_pkg::WRITE_STREAM, 10'h080, 16);
        configure_channel(1, glb_config_pkg::WRITE_STREAM, 10'h2f8, 16);
        run_phase(1'b0);
        configure_channel(0, glb_config_pkg::READ_STREAM, 10'h080, 16);
        configure_channel(1, glb_config_pkg::READ_STREAM, 10'h2f8, 16);
        run_phase(1'b0);

        // chained groups, channel 1 writes go nowhere
        set_switch(1'b0);
        configure_channel(0, glb_config_pkg::WRITE_STREAM, 10'h1f6, 20);
        configure_channel(1, glb_config_pkg::WRITE_STREAM, 10'h2fc, 12);
        run_phase(1'b0);
        configure_channel(0, glb_config_pkg::READ_STREAM, 10'h1f6, 20);
        configure_channel(1, glb_config_pkg::IDLE, 10'h000, 0);
        run_phase(1'b0);
        configure_channel(0, glb_config_pkg::READ_STREAM, 10'h2fc, 12);
        run_phase(1'b0);

        // random stalls on both channels
        set_switch(1'b1);
        configure_channel(0, glb_config_pkg::WRITE_STREAM, 10'h040, 32);
        configure_channel(1, glb_config_pkg::WRITE_STREAM, 10'h240, 32);
        run_phase(1'b1);
        configure_channel(0, glb_config_pkg::READ_STREAM, 10'h040, 32);
        configure_channel(1, glb_config_pkg::READ_STREAM, 10'h240, 32);
        run_phase(1'b1);

        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
